//--- list.f
verilog/lpc_pkg.sv
verilog/autocorr_loader.sv
verilog/fixed_divider.sv
verilog/scratch_ram.sv
verilog/levinson_fsm.sv
verilog/coef_reader.sv
verilog/lpc_top.sv
verif/tb_clock.sv
verif/lpc_checker.sv
verif/tb_lpc.sv

//--- run_sim.sh
#!/bin/sh
# Build with Verilator, run, and decide pass or fail from the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f list.f --top-module tb_lpc -o lpc_sim \
	> build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/lpc_sim > sim.log 2>&1 || true

grep -qx "TEST OK" sim.log && echo "Simulation passed" || { echo "Simulation failed, see sim.log"; exit 1; }

//--- verif/lpc_checker.sv
`timescale 1ns/1ps

module lpc_checker #(
	parameter int LPC_ORDER = 10
) (
	input  logic                           clock,
	input  logic                           i_rst_n,
	input  logic                           i_load_en,
	input  lpc_pkg::coef_t                 i_load_data,
	input  logic                           i_start,
	input  logic                           i_busy,
	input  logic                           i_done,
	input  logic                           i_coef_valid,
	input  logic [$clog2(LPC_ORDER+1)-1:0] i_coef_index,
	input  lpc_pkg::coef_t                 i_coef_data,
	input  lpc_pkg::acc_t                  i_pred_err,
	output int                             o_error_count,
	output int                             o_coef_checks,
	output int                             o_err_checks
);

	import lpc_pkg::*;

	// Copy of the loader bank rebuilt from the strobes
	coef_t r_model [0:LPC_ORDER];
	int wr_ptr;
	longint exp_a [1:LPC_ORDER];
	longint exp_err;
	logic pending;
	logic rst_q;
	logic valid_q;
	logic busy_q;
	logic start_q;
	logic done_q;
	logic done_q2;
	acc_t err_q;
	int next_idx;

	function automatic longint sat32(input longint v);
		if (v > 64'sd2147483647)
			return 64'sd2147483647;
		if (v < -64'sd2147483648)
			return -64'sd2147483648;
		return v;
	endfunction

	function automatic longint sat16(input longint v);
		if (v > 64'sd32767)
			return 64'sd32767;
		if (v < -64'sd32768)
			return -64'sd32768;
		return v;
	endfunction

	////////////////////
	// Levinson-Durbin reference
	////////////////////

	function automatic void lpc_reference(input coef_t r [0:LPC_ORDER],
		output longint a_out [1:LPC_ORDER], output longint err_out);
		longint a [1:LPC_ORDER];
		longint a_new [1:LPC_ORDER];
		longint err;
		longint acc;
		longint mag;
		longint q;
		longint k;
		longint kk;
		err = longint'(r[0]);
		for (int n = 1; n <= LPC_ORDER; n++)
			a[n] = 0;
		for (int i = 1; i <= LPC_ORDER; i++)
		begin
			acc = longint'(r[i]) * 32768;
			for (int j = 1; j < i; j++)
				acc = sat32(acc + a[j] * longint'(r[i-j]));
			mag = (acc < 0) ? -acc : acc;
			if (mag >= err * 32768)
				q = 32767;
			else
				q = mag / err;
			// Sign opposite to acc
			k = (acc < 0) ? q : -q;
			for (int j = 1; j < i; j++)
				a_new[j] = sat16(a[j] + ((k * a[i-j]) >>> 15));
			for (int j = 1; j < i; j++)
				a[j] = a_new[j];
			a[i] = k;
			kk = (k * k) >>> 15;
			err = err - ((err * kk) >>> 15);
			if (err < 1)
				err = 1;
		end
		a_out = a;
		err_out = err;
	endfunction

	initial
	begin
		for (int n = 0; n <= LPC_ORDER; n++)
			r_model[n] = '0;
		o_error_count = 0;
		o_coef_checks = 0;
		o_err_checks = 0;
	end

	////////////////////
	// Monitor and compare
	////////////////////

	always @(posedge clock)
	begin
		rst_q <= i_rst_n;
		if (!i_rst_n)
		begin
			wr_ptr = 0;
			pending = 1'b0;
			next_idx = 1;
			valid_q <= 1'b0;
			busy_q <= 1'b0;
			start_q <= 1'b0;
			done_q <= 1'b0;
			done_q2 <= 1'b0;
		end
		else
		begin
			// First cycle out of reset
			if (!rst_q && (i_busy !== 1'b0 || i_done !== 1'b0 || i_coef_valid !== 1'b0
				|| i_pred_err !== '0))
			begin
				$display("Outputs are not idle after reset");
				o_error_count++;
			end
			// Busy rises one edge after an accepted start
			if (start_q && i_busy !== 1'b1)
			begin
				$display("Busy did not rise after an accepted start");
				o_error_count++;
			end
			// Error output holds between done pulses
			if (rst_q && !i_done && i_pred_err !== err_q)
			begin
				$display("Mismatch o_pred_err: got %h, expected %h", i_pred_err, err_q);
				o_error_count++;
			end
			if (i_done)
			begin
				wr_ptr = 0;
				if (i_busy !== 1'b0 || busy_q !== 1'b1)
				begin
					$display("Done pulse did not come with the fall of busy");
					o_error_count++;
				end
				if (!pending)
				begin
					$display("Done pulse seen with no run in progress");
					o_error_count++;
				end
				else if (i_pred_err !== acc_t'(exp_err))
				begin
					$display("Mismatch o_pred_err: got %h, expected %h",
						i_pred_err, acc_t'(exp_err));
					o_error_count++;
				end
				o_err_checks++;
				pending = 1'b0;
				next_idx = 1;
			end
			else if (i_load_en && !i_busy)
			begin
				r_model[wr_ptr] = i_load_data;
				wr_ptr = (wr_ptr == LPC_ORDER) ? 0 : wr_ptr + 1;
			end
			if (i_start && !i_busy)
			begin
				lpc_reference(r_model, exp_a, exp_err);
				pending = 1'b1;
			end
			// Stream starts two cycles after done
			if ((i_coef_valid && !valid_q) !== done_q2)
			begin
				$display("Coefficient stream did not start two cycles after done");
				o_error_count++;
			end
			if (i_coef_valid)
			begin
				if (next_idx > LPC_ORDER)
				begin
					$display("Coefficient stream longer than %0d words", LPC_ORDER);
					o_error_count++;
				end
				else if (int'(i_coef_index) != next_idx)
				begin
					$display("Mismatch o_coef_index: got %h, expected %h",
						i_coef_index, next_idx);
					o_error_count++;
				end
				else if (i_coef_data !== coef_t'(exp_a[next_idx]))
				begin
					$display("Mismatch o_coef_data[%0d]: got %h, expected %h",
						next_idx, i_coef_data, coef_t'(exp_a[next_idx]));
					o_error_count++;
				end
				o_coef_checks++;
				if (next_idx <= LPC_ORDER)
					next_idx++;
			end
			else if (valid_q && next_idx != LPC_ORDER + 1)
			begin
				$display("Coefficient stream ended after %0d words", next_idx - 1);
				o_error_count++;
			end
			valid_q <= i_coef_valid;
			busy_q <= i_busy;
			start_q <= i_start && !i_busy;
			done_q <= i_done;
			done_q2 <= done_q;
			err_q <= i_pred_err;
		end
	end

endmodule

//--- verif/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
	parameter int RESET_CYCLES = 5
) (
	output logic clock,
	output logic o_rst_n
);

	// 10 ns period
	initial
	begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	initial
	begin
		o_rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clock);
		o_rst_n <= 1'b1;
	end

endmodule

//--- verif/tb_lpc.sv
`timescale 1ns/1ps

module tb_lpc;

	import lpc_pkg::*;

	localparam int ORDER = 10;
	localparam int IDX_W = $clog2(ORDER + 1);
	localparam int RUNS = 24;
	localparam int LIMIT = RUNS * (ORDER * (ORDER * 3 + 40) + 50);

	logic clock;
	logic rst_n;
	logic i_load_en;
	coef_t i_load_data;
	logic i_start;
	logic o_busy;
	logic o_done;
	logic o_coef_valid;
	logic [IDX_W-1:0] o_coef_index;
	coef_t o_coef_data;
	acc_t o_pred_err;
	int error_count;
	int coef_checks;
	int err_checks;
	int cycles;
	logic [31:0] lfsr_state;
	coef_t r_set [0:ORDER];

	tb_clock #(.RESET_CYCLES(5)) clk_i (.clock(clock), .o_rst_n(rst_n));

	lpc_top #(.LPC_ORDER(ORDER)) dut_i (
		.clock(clock),
		.i_rst_n(rst_n),
		.i_load_en(i_load_en),
		.i_load_data(i_load_data),
		.i_start(i_start),
		.o_busy(o_busy),
		.o_done(o_done),
		.o_coef_valid(o_coef_valid),
		.o_coef_index(o_coef_index),
		.o_coef_data(o_coef_data),
		.o_pred_err(o_pred_err)
	);

	lpc_checker #(.LPC_ORDER(ORDER)) checker_i (
		.clock(clock),
		.i_rst_n(rst_n),
		.i_load_en(i_load_en),
		.i_load_data(i_load_data),
		.i_start(i_start),
		.i_busy(o_busy),
		.i_done(o_done),
		.i_coef_valid(o_coef_valid),
		.i_coef_index(o_coef_index),
		.i_coef_data(o_coef_data),
		.i_pred_err(o_pred_err),
		.o_error_count(error_count),
		.o_coef_checks(coef_checks),
		.o_err_checks(err_checks)
	);

	// Galois form with taps for x^32+x^22+x^2+x+1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	task automatic take_bits(input int n, output int v);
		v = 0;
		for (int b = 0; b < n; b++)
		begin
			v = (v << 1) | int'(lfsr_state[0]);
			lfsr_state = lfsr_next(lfsr_state);
		end
	endtask

	task automatic make_random_set();
		int r0;
		int mag;
		int sgn;
		take_bits(14, r0);
		r0 = r0 + 16384;
		r_set[0] = coef_t'(r0);
		for (int i = 1; i <= ORDER; i++)
		begin
			take_bits(15, mag);
			take_bits(1, sgn);
			// Keeps |r[i]| below r[0]
			mag = (mag * r0) >> 15;
			r_set[i] = coef_t'(sgn != 0 ? -mag : mag);
		end
	endtask

	task automatic load_words(input int count);
		for (int i = 0; i < count; i++)
		begin
			@(posedge clock);
			i_load_en <= 1'b1;
			i_load_data <= r_set[i % (ORDER + 1)];
		end
		@(posedge clock);
		i_load_en <= 1'b0;
	endtask

	task automatic pulse_start();
		@(posedge clock);
		i_start <= 1'b1;
		@(posedge clock);
		i_start <= 1'b0;
	endtask

	// Waits for done and then for the whole coefficient stream
	task automatic finish_run();
		do
			@(posedge clock);
		while (!o_done);
		do
			@(posedge clock);
		while (!o_coef_valid);
		do
			@(posedge clock);
		while (o_coef_valid);
	endtask

	task automatic full_run();
		load_words(ORDER + 1);
		pulse_start();
		finish_run();
	endtask

	always @(posedge clock)
	begin
		cycles <= cycles + 1;
		if (cycles >= LIMIT)
		begin
			$display("Run stopped after %0d cycles without finishing", cycles);
			$display("errors %0d, coefficient checks %0d, error checks %0d",
				error_count, coef_checks, err_checks);
			$display("TEST FAILED");
			$finish;
		end
	end

	initial
	begin
		cycles = 0;
		lfsr_state = 32'hd548;
		i_load_en = 1'b0;
		i_load_data = '0;
		i_start = 1'b0;
		do
			@(posedge clock);
		while (!rst_n);
		repeat (3) @(posedge clock);

		// Decaying set
		r_set = '{16'sd32000, 16'sd28000, 16'sd22000, 16'sd15000, 16'sd9000,
			16'sd4000, 16'sd500, -16'sd2000, -16'sd3500, -16'sd4000, -16'sd3800};
		full_run();

		////////////////////
		// Random sets
		////////////////////
		for (int n = 0; n < 20; n++)
		begin
			make_random_set();
			// Extra words wrap the write pointer
			if (n % 4 == 1)
				load_words(ORDER + 1 + 5);
			// Partial load leaves the pointer mid-bank before the rewind
			else if (n % 5 == 2)
				load_words(4);
			else
				load_words(ORDER + 1);
			pulse_start();
			finish_run();
		end

		// r[1] equal to r[0] saturates k
		r_set = '{16'sd20000, 16'sd20000, 16'sd12000, 16'sd6000, 16'sd1000, -16'sd500,
			-16'sd1500, -16'sd2000, -16'sd1000, 16'sd300, 16'sd900};
		full_run();

		// Start and loads while busy are ignored
		make_random_set();
		load_words(ORDER + 1);
		pulse_start();
		repeat (20) @(posedge clock);
		i_start <= 1'b1;
		i_load_en <= 1'b1;
		i_load_data <= 16'sh7abc;
		repeat (3) @(posedge clock);
		i_start <= 1'b0;
		i_load_en <= 1'b0;
		finish_run();
		// Same r values again without loading
		pulse_start();
		finish_run();
		repeat (5) @(posedge clock);

		$display("errors %0d, coefficient checks %0d, error checks %0d",
			error_count, coef_checks, err_checks);
		if (error_count == 0 && err_checks == RUNS && coef_checks == RUNS * ORDER)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

//--- verilog/autocorr_loader.sv
`timescale 1ns/1ps

module autocorr_loader #(
	parameter int LPC_ORDER = lpc_pkg::LPC_ORDER_DEFAULT
) (
	input  logic                           clock,
	input  logic                           i_rst_n,
	input  logic                           i_load_en,
	input  lpc_pkg::coef_t                 i_load_data,
	input  logic                           i_busy,
	input  logic                           i_clear,
	input  logic [$clog2(LPC_ORDER+1)-1:0] i_r_index,
	output lpc_pkg::coef_t                 o_r_value
);

	import lpc_pkg::*;

	localparam int IDX_W = $clog2(LPC_ORDER + 1);

	// Holds r[0..LPC_ORDER]
	coef_t bank [0:LPC_ORDER];
	logic [IDX_W-1:0] wr_ptr;
	logic load_ok;

	// Strobes are dropped while the recursion runs
	assign load_ok = i_load_en && !i_busy && !i_clear;

	always_ff @(posedge clock)
	begin
		if (!i_rst_n)
			wr_ptr <= '0;
		else if (i_clear)
			wr_ptr <= '0;
		else if (load_ok)
		begin
			if (wr_ptr == IDX_W'(LPC_ORDER))
				wr_ptr <= '0;
			else
				wr_ptr <= wr_ptr + 1'b1;
		end
	end

	always_ff @(posedge clock)
	begin
		if (load_ok)
			bank[wr_ptr] <= i_load_data;
	end

	// Combinational lookup for the FSM
	assign o_r_value = bank[i_r_index];

endmodule

//--- verilog/coef_reader.sv
`timescale 1ns/1ps

module coef_reader #(
	parameter int LPC_ORDER = lpc_pkg::LPC_ORDER_DEFAULT
) (
	input  logic                           clock,
	input  logic                           i_rst_n,
	input  logic                           i_start,
	input  logic                           i_bank,
	input  lpc_pkg::coef_t                 i_rd_data,
	output logic [$clog2(LPC_ORDER+1)-1:0] o_rd_addr,
	output logic                           o_rd_bank,
	output logic                           o_coef_valid,
	output logic [$clog2(LPC_ORDER+1)-1:0] o_coef_index,
	output lpc_pkg::coef_t                 o_coef_data
);

	localparam int IDX_W = $clog2(LPC_ORDER + 1);

	logic active;
	logic [IDX_W-1:0] addr;

	// Valid and index lag the address walk by one RAM read
	always_ff @(posedge clock)
	begin
		if (!i_rst_n)
		begin
			active <= 1'b0;
			addr <= '0;
			o_coef_valid <= 1'b0;
			o_coef_index <= '0;
		end
		else
		begin
			o_coef_valid <= active;
			o_coef_index <= addr + 1'b1;
			if (i_start)
			begin
				active <= 1'b1;
				addr <= '0;
			end
			else if (active)
			begin
				if (addr == IDX_W'(LPC_ORDER - 1))
				begin
					active <= 1'b0;
					addr <= '0;
				end
				else
					addr <= addr + 1'b1;
			end
		end
	end

	// Bank with the final coefficients
	always_ff @(posedge clock)
	begin
		if (i_start)
			o_rd_bank <= i_bank;
	end

	assign o_rd_addr = addr;
	assign o_coef_data = i_rd_data;

endmodule

//--- verilog/fixed_divider.sv
`timescale 1ns/1ps

module fixed_divider (
	input  logic           clock,
	input  logic           i_rst_n,
	input  logic           i_start,
	input  lpc_pkg::acc_t  i_num,
	input  lpc_pkg::acc_t  i_den,
	output lpc_pkg::coef_t o_quot,
	output logic           o_done
);

	import lpc_pkg::*;

	localparam int QBITS = SAMPLE_W - 1;
	localparam int WIDE_W = ACC_W + QBITS + 1;
	localparam int CNT_W = $clog2(QBITS + 1);

	logic [WIDE_W-1:0] num_w;
	logic [WIDE_W-1:0] den_sh;
	logic [WIDE_W-1:0] rem;
	logic [WIDE_W-1:0] dvs;
	logic [QBITS-1:0] quot;
	logic sat;
	logic running;
	logic [CNT_W-1:0] count;

	// Numerator is a magnitude, so 0x80000000 reads as 2^31
	assign num_w = WIDE_W'($unsigned(i_num));
	assign den_sh = WIDE_W'($unsigned(i_den)) << QBITS;

	////////////////////
	// Sequencing
	////////////////////

	always_ff @(posedge clock)
	begin
		if (!i_rst_n)
		begin
			running <= 1'b0;
			count <= '0;
			o_done <= 1'b0;
		end
		else
		begin
			o_done <= 1'b0;
			if (i_start)
			begin
				running <= 1'b1;
				count <= '0;
			end
			else if (running)
			begin
				if (count == CNT_W'(QBITS))
				begin
					running <= 1'b0;
					o_done <= 1'b1;
				end
				else
					count <= count + 1'b1;
			end
		end
	end

	////////////////////
	// Restoring datapath
	////////////////////

	always_ff @(posedge clock)
	begin
		if (i_start)
		begin
			rem <= num_w;
			// First trial divisor is den << 14
			dvs <= den_sh >> 1;
			sat <= (num_w >= den_sh);
			quot <= '0;
		end
		else if (running)
		begin
			if (count == CNT_W'(QBITS))
				o_quot <= sat ? coef_t'(2**QBITS - 1) : coef_t'({1'b0, quot});
			else
			begin
				if (rem >= dvs)
				begin
					rem <= rem - dvs;
					quot <= {quot[QBITS-2:0], 1'b1};
				end
				else
					quot <= {quot[QBITS-2:0], 1'b0};
				dvs <= dvs >> 1;
			end
		end
	end

endmodule

//--- verilog/levinson_fsm.sv
`timescale 1ns/1ps

module levinson_fsm #(
	parameter int LPC_ORDER = lpc_pkg::LPC_ORDER_DEFAULT
) (
	input  logic                           clock,
	input  logic                           i_rst_n,
	input  logic                           i_start,
	input  lpc_pkg::coef_t                 i_r_value,
	input  lpc_pkg::coef_t                 i_rd_data,
	input  lpc_pkg::coef_t                 i_div_quot,
	input  logic                           i_div_done,
	output logic                           o_busy,
	output logic                           o_done,
	output logic [$clog2(LPC_ORDER+1)-1:0] o_r_index,
	output logic                           o_div_start,
	output lpc_pkg::acc_t                  o_div_num,
	output lpc_pkg::acc_t                  o_div_den,
	output logic                           o_wr_en,
	output logic                           o_wr_bank,
	output logic [$clog2(LPC_ORDER+1)-1:0] o_wr_addr,
	output lpc_pkg::coef_t                 o_wr_data,
	output logic                           o_rd_bank,
	output logic [$clog2(LPC_ORDER+1)-1:0] o_rd_addr,
	output logic                           o_final_bank,
	output lpc_pkg::acc_t                  o_pred_err
);

	import lpc_pkg::*;

	localparam int IDX_W = $clog2(LPC_ORDER + 1);
	localparam int Q = SAMPLE_W - 1;

	typedef logic signed [ACC_W:0] acc_ext_t;
	typedef logic signed [2*ACC_W-1:0] wide_t;
	typedef enum logic [2:0] {st_idle, st_mac, st_divide, st_update, st_error, st_next} state_t;

	state_t state;
	logic [IDX_W-1:0] step;
	logic [IDX_W-1:0] j;
	logic [IDX_W-1:0] j_pipe;
	logic pipe_valid;
	logic [1:0] phase;
	logic bank;
	acc_t acc;
	acc_t err;
	coef_t k;
	coef_t a_hold;

	acc_t mac_prod;
	acc_ext_t mac_wide;
	acc_t upd_prod;
	acc_t upd_sum;
	acc_t kk;
	wide_t err_dec;
	wide_t err_diff;
	acc_t err_next;

	function automatic acc_t sat32(input acc_ext_t v);
		// Top two bits differ on overflow
		if (v[ACC_W] != v[ACC_W-1])
			return v[ACC_W] ? {1'b1, {(ACC_W-1){1'b0}}} : {1'b0, {(ACC_W-1){1'b1}}};
		return v[ACC_W-1:0];
	endfunction

	function automatic coef_t sat16(input acc_t v);
		if (v > acc_t'(2**Q - 1))
			return coef_t'(2**Q - 1);
		if (v < -acc_t'(2**Q))
			return coef_t'(-(2**Q));
		return v[SAMPLE_W-1:0];
	endfunction

	////////////////////
	// Arithmetic
	////////////////////

	always_comb
	begin
		// acc + a[j]*r[i-j]
		mac_prod = acc_t'(i_rd_data) * acc_t'(i_r_value);
		mac_wide = acc_ext_t'(acc) + acc_ext_t'(mac_prod);
		// a[j] + (k*a[i-j]) >> 15
		upd_prod = acc_t'(k) * acc_t'(i_rd_data);
		upd_sum = acc_t'(a_hold) + (upd_prod >>> Q);
		// err - err*(k*k >> 15) >> 15 with a floor of 1
		kk = (acc_t'(k) * acc_t'(k)) >>> Q;
		err_dec = (wide_t'(err) * wide_t'(kk)) >>> Q;
		err_diff = wide_t'(err) - err_dec;
		err_next = (err_diff < 1) ? acc_t'(1) : acc_t'(err_diff);
	end

	assign o_div_num = acc[ACC_W-1] ? -acc : acc;
	assign o_div_den = err;
	assign o_rd_bank = bank;
	assign o_wr_bank = ~bank;

	// Addresses and write port by state
	always_comb
	begin
		o_r_index = '0;
		o_rd_addr = '0;
		o_wr_en = 1'b0;
		o_wr_addr = step - 1'b1;
		o_wr_data = k;
		case (state)
			st_mac:
			begin
				o_r_index = step - j_pipe;
				o_rd_addr = j - 1'b1;
			end
			st_update:
			begin
				// Last write of a step stores a[i] = k
				if (j == step)
					o_wr_en = 1'b1;
				else if (phase == 2'd1)
					o_rd_addr = step - j - 1'b1;
				else if (phase == 2'd2)
				begin
					o_wr_en = 1'b1;
					o_wr_addr = j - 1'b1;
					o_wr_data = sat16(upd_sum);
				end
				else
					o_rd_addr = j - 1'b1;
			end
			st_next:
			begin
				if (step != IDX_W'(LPC_ORDER))
					o_r_index = step + 1'b1;
			end
			default: ;
		endcase
	end

	////////////////////
	// Control FSM
	////////////////////

	always_ff @(posedge clock)
	begin
		if (!i_rst_n)
		begin
			state <= st_idle;
			o_busy <= 1'b0;
			o_done <= 1'b0;
			o_div_start <= 1'b0;
			o_pred_err <= '0;
			o_final_bank <= 1'b0;
			bank <= 1'b0;
			step <= '0;
			j <= '0;
			j_pipe <= '0;
			pipe_valid <= 1'b0;
			phase <= '0;
		end
		else
		begin
			o_done <= 1'b0;
			o_div_start <= 1'b0;
			case (state)
				st_idle:
				begin
					// Step 0 goes through NEXT to set up step 1
					if (i_start)
					begin
						o_busy <= 1'b1;
						step <= '0;
						state <= st_next;
					end
				end
				st_mac:
				begin
					pipe_valid <= (j != step);
					j_pipe <= j;
					if (j != step)
						j <= j + 1'b1;
					else if (!pipe_valid)
					begin
						o_div_start <= 1'b1;
						state <= st_divide;
					end
				end
				st_divide:
				begin
					if (i_div_done)
					begin
						j <= IDX_W'(1);
						phase <= '0;
						state <= st_update;
					end
				end
				st_update:
				begin
					if (j == step)
						state <= st_error;
					else if (phase == 2'd2)
					begin
						phase <= '0;
						j <= j + 1'b1;
					end
					else
						phase <= phase + 1'b1;
				end
				st_error:
					state <= st_next;
				default:
				begin
					bank <= ~bank;
					j <= IDX_W'(1);
					j_pipe <= '0;
					pipe_valid <= 1'b0;
					if (step == IDX_W'(LPC_ORDER))
					begin
						o_busy <= 1'b0;
						o_done <= 1'b1;
						o_pred_err <= err;
						o_final_bank <= ~bank;
						state <= st_idle;
					end
					else
					begin
						step <= step + 1'b1;
						state <= st_mac;
					end
				end
			endcase
		end
	end

	// Recursion values
	always_ff @(posedge clock)
	begin
		case (state)
			st_idle:
			begin
				if (i_start)
					err <= acc_t'(i_r_value);
			end
			st_mac:
			begin
				if (pipe_valid)
					acc <= sat32(mac_wide);
			end
			st_divide:
			begin
				// k takes the sign opposite to acc
				if (i_div_done)
					k <= acc[ACC_W-1] ? i_div_quot : -i_div_quot;
			end
			st_update:
			begin
				if (phase == 2'd1)
					a_hold <= i_rd_data;
			end
			st_error:
				err <= err_next;
			default:
				acc <= acc_t'(i_r_value) <<< Q;
		endcase
	end

endmodule

//--- verilog/lpc_pkg.sv
package lpc_pkg;

	////////////////////
	// Sizes shared by the solver
	////////////////////

	// Prediction order when the top level does not override it
	parameter int LPC_ORDER_DEFAULT = 10;

	// Autocorrelation words and Q15 coefficients
	parameter int SAMPLE_W = 16;

	// Accumulator and prediction error
	parameter int ACC_W = 32;

	typedef logic signed [SAMPLE_W-1:0] coef_t;
	typedef logic signed [ACC_W-1:0] acc_t;

endpackage

//--- verilog/lpc_top.sv
`timescale 1ns/1ps

module lpc_top #(
	parameter int LPC_ORDER = lpc_pkg::LPC_ORDER_DEFAULT
) (
	input  logic                           clock,
	input  logic                           i_rst_n,
	input  logic                           i_load_en,
	input  lpc_pkg::coef_t                 i_load_data,
	input  logic                           i_start,
	output logic                           o_busy,
	output logic                           o_done,
	output logic                           o_coef_valid,
	output logic [$clog2(LPC_ORDER+1)-1:0] o_coef_index,
	output lpc_pkg::coef_t                 o_coef_data,
	output lpc_pkg::acc_t                  o_pred_err
);

	import lpc_pkg::*;

	localparam int IDX_W = $clog2(LPC_ORDER + 1);

	logic [IDX_W-1:0] r_index;
	coef_t r_value;
	logic div_start;
	logic div_done;
	acc_t div_num;
	acc_t div_den;
	coef_t div_quot;
	logic wr_en;
	logic wr_bank;
	logic [IDX_W-1:0] wr_addr;
	coef_t wr_data;
	logic rd_bank_a;
	logic [IDX_W-1:0] rd_addr_a;
	coef_t rd_data_a;
	logic rd_bank_b;
	logic [IDX_W-1:0] rd_addr_b;
	coef_t rd_data_b;
	logic final_bank;

	// Input side
	autocorr_loader #(
		.LPC_ORDER(LPC_ORDER)
	) u_loader (
		.clock(clock),
		.i_rst_n(i_rst_n),
		.i_load_en(i_load_en),
		.i_load_data(i_load_data),
		.i_busy(o_busy),
		.i_clear(o_done),
		.i_r_index(r_index),
		.o_r_value(r_value)
	);

	levinson_fsm #(
		.LPC_ORDER(LPC_ORDER)
	) u_fsm (
		.clock(clock),
		.i_rst_n(i_rst_n),
		.i_start(i_start),
		.i_r_value(r_value),
		.i_rd_data(rd_data_a),
		.i_div_quot(div_quot),
		.i_div_done(div_done),
		.o_busy(o_busy),
		.o_done(o_done),
		.o_r_index(r_index),
		.o_div_start(div_start),
		.o_div_num(div_num),
		.o_div_den(div_den),
		.o_wr_en(wr_en),
		.o_wr_bank(wr_bank),
		.o_wr_addr(wr_addr),
		.o_wr_data(wr_data),
		.o_rd_bank(rd_bank_a),
		.o_rd_addr(rd_addr_a),
		.o_final_bank(final_bank),
		.o_pred_err(o_pred_err)
	);

	fixed_divider u_divider (
		.clock(clock),
		.i_rst_n(i_rst_n),
		.i_start(div_start),
		.i_num(div_num),
		.i_den(div_den),
		.o_quot(div_quot),
		.o_done(div_done)
	);

	scratch_ram #(
		.LPC_ORDER(LPC_ORDER)
	) u_ram (
		.clock(clock),
		.i_wr_en(wr_en),
		.i_wr_bank(wr_bank),
		.i_wr_addr(wr_addr),
		.i_wr_data(wr_data),
		.i_rd_bank_a(rd_bank_a),
		.i_rd_addr_a(rd_addr_a),
		.i_rd_bank_b(rd_bank_b),
		.i_rd_addr_b(rd_addr_b),
		.o_rd_data_a(rd_data_a),
		.o_rd_data_b(rd_data_b)
	);

	// Output side
	coef_reader #(
		.LPC_ORDER(LPC_ORDER)
	) u_reader (
		.clock(clock),
		.i_rst_n(i_rst_n),
		.i_start(o_done),
		.i_bank(final_bank),
		.i_rd_data(rd_data_b),
		.o_rd_addr(rd_addr_b),
		.o_rd_bank(rd_bank_b),
		.o_coef_valid(o_coef_valid),
		.o_coef_index(o_coef_index),
		.o_coef_data(o_coef_data)
	);

endmodule

//--- verilog/scratch_ram.sv
`timescale 1ns/1ps

module scratch_ram #(
	parameter int LPC_ORDER = lpc_pkg::LPC_ORDER_DEFAULT
) (
	input  logic                           clock,
	input  logic                           i_wr_en,
	input  logic                           i_wr_bank,
	input  logic [$clog2(LPC_ORDER+1)-1:0] i_wr_addr,
	input  lpc_pkg::coef_t                 i_wr_data,
	input  logic                           i_rd_bank_a,
	input  logic [$clog2(LPC_ORDER+1)-1:0] i_rd_addr_a,
	input  logic                           i_rd_bank_b,
	input  logic [$clog2(LPC_ORDER+1)-1:0] i_rd_addr_b,
	output lpc_pkg::coef_t                 o_rd_data_a,
	output lpc_pkg::coef_t                 o_rd_data_b
);

	import lpc_pkg::*;

	// Address k-1 holds a[k] in each bank
	coef_t mem [0:1][0:LPC_ORDER-1];

	always_ff @(posedge clock)
	begin
		if (i_wr_en)
			mem[i_wr_bank][i_wr_addr] <= i_wr_data;
	end

	// Port A serves the recursion
	always_ff @(posedge clock)
	begin
		o_rd_data_a <= mem[i_rd_bank_a][i_rd_addr_a];
	end

	// Port B serves the output stream
	always_ff @(posedge clock)
	begin
		o_rd_data_b <= mem[i_rd_bank_b][i_rd_addr_b];
	end

endmodule
